// ==== logic/riders_addr_decode.sv ====
`timescale 1ns/1ps
`include "riders_params.svh"

module riders_addr_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  riders_pkg::cpu_bus_t cpu,
    input  logic                 cpu_req,
    input  logic                 br,
    input  logic                 bgack,
    input  logic [15:0]          oram_dout,
    input  logic [15:0]          prot_dout,
    input  logic [15:0]          snd_dout,
    output logic                 cpu_ack,
    output logic [15:0]          cpu_dout,
    output logic                 oram_cs,
    output logic                 prot_cs,
    output logic                 snd_cs,
    output logic                 bg
);

    localparam int AW     = `RIDERS_AW;
    localparam int PROT_W = $clog2(`RIDERS_PROT_NREG);
    localparam logic [AW-1:0] PROT_BASE = `RIDERS_PROT_BASE;
    localparam logic [AW-1:0] SND_BASE  = `RIDERS_SND_BASE;

    riders_pkg::bus_state_e state;

    logic       hit_oram;
    logic       hit_prot;
    logic       hit_snd;
    logic       start;
    logic       data_phase;
    logic [2:0] hit_q;
    logic [15:0] rd_mux;

    // Address map
    assign hit_oram = cpu.addr[AW-1:`RIDERS_ORAM_AW] == '0;
    assign hit_prot = cpu.addr[AW-1:PROT_W] == PROT_BASE[AW-1:PROT_W];
    assign hit_snd  = cpu.addr[AW-1:1] == SND_BASE[AW-1:1];

    // A cycle may start only while DMA neither asks for nor holds the bus
    always_comb begin
        start = 1'b0;
        case (state)
            riders_pkg::bus_idle:       start = cpu_req && !(br || bg || bgack);
            riders_pkg::bus_wait_grant: start = !(br || bg || bgack);
            default:                    start = 1'b0;
        endcase
    end

    always_comb begin
        if (hit_q[0])
            rd_mux = oram_dout;
        else if (hit_q[1])
            rd_mux = prot_dout;
        else if (hit_q[2])
            rd_mux = snd_dout;
        else
            rd_mux = 16'h0000;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= riders_pkg::bus_idle;
            oram_cs    <= 1'b0;
            prot_cs    <= 1'b0;
            snd_cs     <= 1'b0;
            data_phase <= 1'b0;
            cpu_ack    <= 1'b0;
        end else begin
            // Strobes last a single cycle
            oram_cs <= start && hit_oram;
            prot_cs <= start && hit_prot;
            snd_cs  <= start && hit_snd;
            case (state)
                riders_pkg::bus_idle: begin
                    if (start)
                        state <= riders_pkg::bus_access;
                    else if (cpu_req)
                        state <= riders_pkg::bus_wait_grant;
                end
                riders_pkg::bus_wait_grant: begin
                    if (start)
                        state <= riders_pkg::bus_access;
                end
                riders_pkg::bus_access: begin
                    // Peripheral data is valid in the second cycle
                    data_phase <= !data_phase;
                    if (data_phase) begin
                        cpu_ack <= 1'b1;
                        state   <= riders_pkg::bus_ack_hold;
                    end
                end
                riders_pkg::bus_ack_hold: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= riders_pkg::bus_idle;
                    end
                end
                default: state <= riders_pkg::bus_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            hit_q <= {hit_snd, hit_prot, hit_oram};
        if (state == riders_pkg::bus_access && data_phase)
            cpu_dout <= rd_mux;
    end

    // Grant only between CPU cycles and release once DMA lets go
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bg <= 1'b0;
        end else if (!bg && br && (state == riders_pkg::bus_idle ||
                                   state == riders_pkg::bus_wait_grant)) begin
            bg <= 1'b1;
        end else if (bg && !br && !bgack) begin
            bg <= 1'b0;
        end
    end

endmodule

// ==== logic/riders_game.sv ====
`timescale 1ns/1ps

module riders_game (
    input  logic                 clk,
    input  logic                 rst_n,
    input  riders_pkg::cpu_bus_t cpu,
    input  logic                 cpu_req,
    input  logic                 snd_rd,
    input  logic                 snd_reply_we,
    input  logic [7:0]           snd_reply,
    input  logic [1:0]           debug_sel,
    output logic                 cpu_ack,
    output logic [15:0]          cpu_dout,
    output logic                 prot_irqn,
    output logic                 snd_irq,
    output logic [7:0]           snd_cmd,
    output logic [7:0]           debug_view
);

    riders_pkg::oram_port_t oram_dma;

    logic        oram_cs;
    logic        prot_cs;
    logic        snd_cs;
    logic [15:0] oram_dout;
    logic [15:0] prot_dout;
    logic [15:0] snd_dout;
    logic [15:0] oram_rdata;
    logic        br;
    logic        bg;
    logic        bgack;
    logic        prot_busy;
    logic [7:0]  last_addr;

    riders_addr_decode u_decode (
        .clk       ( clk        ),
        .rst_n     ( rst_n      ),
        .cpu       ( cpu        ),
        .cpu_req   ( cpu_req    ),
        .br        ( br         ),
        .bgack     ( bgack      ),
        .oram_dout ( oram_dout  ),
        .prot_dout ( prot_dout  ),
        .snd_dout  ( snd_dout   ),
        .cpu_ack   ( cpu_ack    ),
        .cpu_dout  ( cpu_dout   ),
        .oram_cs   ( oram_cs    ),
        .prot_cs   ( prot_cs    ),
        .snd_cs    ( snd_cs     ),
        .bg        ( bg         )
    );

    riders_prot u_prot (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cs         ( prot_cs    ),
        .cpu        ( cpu        ),
        .bg         ( bg         ),
        .oram_rdata ( oram_rdata ),
        .dout       ( prot_dout  ),
        .oram_dma   ( oram_dma   ),
        .br         ( br         ),
        .bgack      ( bgack      ),
        .irqn       ( prot_irqn  ),
        .busy       ( prot_busy  )
    );

    riders_oram u_oram (
        .clk       ( clk        ),
        .cs        ( oram_cs    ),
        .cpu       ( cpu        ),
        .dma_sel   ( bgack      ),
        .oram_dma  ( oram_dma   ),
        .dout      ( oram_dout  ),
        .dma_rdata ( oram_rdata )
    );

    riders_snd_latch u_snd (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cs           ( snd_cs       ),
        .cpu          ( cpu          ),
        .snd_rd       ( snd_rd       ),
        .snd_reply_we ( snd_reply_we ),
        .snd_reply    ( snd_reply    ),
        .dout         ( snd_dout     ),
        .snd_cmd      ( snd_cmd      ),
        .snd_irq      ( snd_irq      )
    );

    // Debug view one cycle behind debug_sel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_addr  <= 8'd0;
            debug_view <= 8'd0;
        end else begin
            if (cpu_ack)
                last_addr <= cpu.addr[7:0];
            case (debug_sel)
                2'd0:    debug_view <= {6'd0, !prot_irqn, prot_busy};
                2'd1:    debug_view <= snd_cmd;
                2'd2:    debug_view <= last_addr;
                default: debug_view <= 8'd0;
            endcase
        end
    end

endmodule

// ==== logic/riders_oram.sv ====
`timescale 1ns/1ps
`include "riders_params.svh"

module riders_oram (
    input  logic                   clk,
    input  logic                   cs,
    input  riders_pkg::cpu_bus_t   cpu,
    input  logic                   dma_sel,
    input  riders_pkg::oram_port_t oram_dma,
    output logic [15:0]            dout,
    output logic [15:0]            dma_rdata
);

    localparam int OAW = `RIDERS_ORAM_AW;

    logic [15:0]    mem [0:(1<<OAW)-1];
    logic [OAW-1:0] addr;
    logic [15:0]    wdata;
    logic [1:0]     be;
    logic           we;
    logic [15:0]    rd_q;

    // DMA owns the array while bgack is high
    always_comb begin
        if (dma_sel) begin
            addr  = oram_dma.addr;
            wdata = oram_dma.din;
            we    = oram_dma.we;
            be    = 2'b11;
        end else begin
            addr  = cpu.addr[OAW-1:0];
            wdata = cpu.din;
            we    = cs && cpu.we;
            be    = ~cpu.dsn;
        end
    end

    always_ff @(posedge clk) begin
        if (we && be[0])
            mem[addr][7:0] <= wdata[7:0];
        if (we && be[1])
            mem[addr][15:8] <= wdata[15:8];
        rd_q <= mem[addr];
    end

    assign dout      = rd_q;
    assign dma_rdata = rd_q;

endmodule

// ==== logic/riders_params.svh ====
`ifndef RIDERS_PARAMS_SVH
`define RIDERS_PARAMS_SVH

// CPU word address width
`define RIDERS_AW 12

// Object RAM of 1024 words at 000 to 3FF
`define RIDERS_ORAM_AW 10

// Protection chip register window
`define RIDERS_PROT_BASE 12'h800
`define RIDERS_PROT_NREG 8

// Sound command at C00 and reply at C01
`define RIDERS_SND_BASE 12'hC00

`endif

// ==== logic/riders_pkg.sv ====
`include "riders_params.svh"

package riders_pkg;

    // One CPU bus cycle held stable while cpu_req is high
    typedef struct packed {
        logic [`RIDERS_AW-1:0] addr;
        logic                  we;
        logic [1:0]            dsn;
        logic [15:0]           din;
    } cpu_bus_t;

    // DMA side of the object RAM
    typedef struct packed {
        logic [`RIDERS_ORAM_AW-1:0] addr;
        logic                       we;
        logic [15:0]                din;
    } oram_port_t;

    typedef enum logic [2:0] {
        reg_op_a     = 3'd0,
        reg_op_b     = 3'd1,
        reg_result   = 3'd2,
        reg_dma_src  = 3'd3,
        reg_dma_dst  = 3'd4,
        reg_dma_len  = 3'd5,
        reg_command  = 3'd6,
        reg_status   = 3'd7
    } prot_reg_e;

    typedef enum logic [1:0] {
        cmd_nop      = 2'd0,
        cmd_mul      = 2'd1,
        cmd_dma_copy = 2'd2,
        cmd_dma_fill = 2'd3
    } prot_cmd_e;

    typedef enum logic [2:0] {
        dma_idle, dma_bus_req, dma_read, dma_write, dma_finish
    } prot_state_e;

    typedef enum logic [1:0] {
        bus_idle, bus_wait_grant, bus_access, bus_ack_hold
    } bus_state_e;

endpackage

// ==== logic/riders_prot.sv ====
`timescale 1ns/1ps
`include "riders_params.svh"

module riders_prot (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cs,
    input  riders_pkg::cpu_bus_t   cpu,
    input  logic                   bg,
    input  logic [15:0]            oram_rdata,
    output logic [15:0]            dout,
    output riders_pkg::oram_port_t oram_dma,
    output logic                   br,
    output logic                   bgack,
    output logic                   irqn,
    output logic                   busy
);

    localparam int SEL_W = $clog2(`RIDERS_PROT_NREG);
    localparam int OAW   = `RIDERS_ORAM_AW;

    riders_pkg::prot_state_e state;
    riders_pkg::prot_reg_e   sel;
    riders_pkg::prot_cmd_e   cmd;
    riders_pkg::prot_cmd_e   last_cmd;

    logic [15:0]    op_a;
    logic [15:0]    op_b;
    logic [15:0]    result;
    logic [15:0]    dma_src;
    logic [15:0]    dma_dst;
    logic [15:0]    dma_len;
    logic [15:0]    mul_lo;
    logic [OAW-1:0] src_ptr;
    logic [OAW-1:0] dst_ptr;
    logic [OAW:0]   count;
    logic           irq_pend;
    logic           wr;
    logic           rd;
    logic           cmd_wr;
    logic           dma_start;

    assign sel    = riders_pkg::prot_reg_e'(cpu.addr[SEL_W-1:0]);
    assign cmd    = riders_pkg::prot_cmd_e'(cpu.din[1:0]);
    assign wr     = cs && cpu.we;
    assign rd     = cs && !cpu.we;
    assign busy   = state != riders_pkg::dma_idle;
    assign irqn   = !irq_pend;
    assign mul_lo = 16'(op_a * op_b);

    // Commands are dropped while a transfer runs
    assign cmd_wr    = wr && sel == riders_pkg::reg_command && !busy;
    assign dma_start = cmd_wr && dma_len[OAW:0] != '0 &&
                       (cmd == riders_pkg::cmd_dma_copy || cmd == riders_pkg::cmd_dma_fill);

    always_ff @(posedge clk) begin
        if (wr) begin
            case (sel)
                riders_pkg::reg_op_a:    op_a    <= cpu.din;
                riders_pkg::reg_op_b:    op_b    <= cpu.din;
                riders_pkg::reg_dma_src: dma_src <= cpu.din;
                riders_pkg::reg_dma_dst: dma_dst <= cpu.din;
                riders_pkg::reg_dma_len: dma_len <= cpu.din;
                default: ;
            endcase
        end
        if (cmd_wr)
            last_cmd <= cmd;
        if (cmd_wr && cmd == riders_pkg::cmd_mul)
            result <= mul_lo;
        if (rd) begin
            case (sel)
                riders_pkg::reg_op_a:    dout <= op_a;
                riders_pkg::reg_op_b:    dout <= op_b;
                riders_pkg::reg_result:  dout <= result;
                riders_pkg::reg_dma_src: dout <= dma_src;
                riders_pkg::reg_dma_dst: dout <= dma_dst;
                riders_pkg::reg_dma_len: dout <= dma_len;
                riders_pkg::reg_command: dout <= {14'd0, last_cmd};
                default:                 dout <= {14'd0, irq_pend, busy};
            endcase
        end
        // Transfer pointers
        if (dma_start) begin
            src_ptr <= dma_src[OAW-1:0];
            dst_ptr <= dma_dst[OAW-1:0];
            count   <= dma_len[OAW:0];
        end else if (state == riders_pkg::dma_write) begin
            src_ptr <= src_ptr + 1'b1;
            dst_ptr <= dst_ptr + 1'b1;
            count   <= count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= riders_pkg::dma_idle;
            br       <= 1'b0;
            bgack    <= 1'b0;
            irq_pend <= 1'b0;
        end else begin
            if (rd && sel == riders_pkg::reg_status)
                irq_pend <= 1'b0;
            case (state)
                riders_pkg::dma_idle: begin
                    if (dma_start) begin
                        br    <= 1'b1;
                        state <= riders_pkg::dma_bus_req;
                    end
                end
                riders_pkg::dma_bus_req: begin
                    if (bg) begin
                        br    <= 1'b0;
                        bgack <= 1'b1;
                        state <= riders_pkg::dma_read;
                    end
                end
                riders_pkg::dma_read: state <= riders_pkg::dma_write;
                riders_pkg::dma_write: begin
                    if (count == 1) begin
                        bgack <= 1'b0;
                        state <= riders_pkg::dma_finish;
                    end else begin
                        state <= riders_pkg::dma_read;
                    end
                end
                riders_pkg::dma_finish: begin
                    irq_pend <= 1'b1;
                    state    <= riders_pkg::dma_idle;
                end
                default: state <= riders_pkg::dma_idle;
            endcase
        end
    end

    // Read phase fetches the source word and write phase stores it or the fill value
    always_comb begin
        oram_dma.we   = state == riders_pkg::dma_write;
        oram_dma.addr = oram_dma.we ? dst_ptr : src_ptr;
        oram_dma.din  = last_cmd == riders_pkg::cmd_dma_fill ? op_a : oram_rdata;
    end

endmodule

// ==== logic/riders_snd_latch.sv ====
`timescale 1ns/1ps

module riders_snd_latch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cs,
    input  riders_pkg::cpu_bus_t cpu,
    input  logic                 snd_rd,
    input  logic                 snd_reply_we,
    input  logic [7:0]           snd_reply,
    output logic [15:0]          dout,
    output logic [7:0]           snd_cmd,
    output logic                 snd_irq
);

    logic [7:0] reply;
    logic       cmd_wr;

    // Low byte lane at the even address carries the command
    assign cmd_wr = cs && cpu.we && !cpu.addr[0] && !cpu.dsn[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_cmd <= 8'd0;
            snd_irq <= 1'b0;
            reply   <= 8'd0;
        end else begin
            if (cmd_wr) begin
                snd_cmd <= cpu.din[7:0];
                snd_irq <= 1'b1;
            end else if (snd_rd) begin
                snd_irq <= 1'b0;
            end
            if (snd_reply_we)
                reply <= snd_reply;
        end
    end

    always_ff @(posedge clk) begin
        if (cs && !cpu.we)
            dout <= {8'd0, cpu.addr[0] ? reply : snd_cmd};
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the riders_game testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module riders_game_tb \
    -o sim_riders_game &&
./obj_dir/sim_riders_game | tee /dev/stderr | grep -qF "Done: no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== test/riders_game_tb.sv ====
`timescale 1ns/1ps
`include "riders_params.svh"

module riders_game_tb;

    localparam int ACK_TIMEOUT = 200;
    localparam int IRQ_TIMEOUT = 300;
    localparam int MAX_STEPS   = 64;
    localparam logic [11:0] PROT = `RIDERS_PROT_BASE;
    localparam logic [11:0] SND  = `RIDERS_SND_BASE;

    // One row of the stimulus table
    typedef struct packed {
        logic        is_rd;
        logic [11:0] addr;
        logic [1:0]  dsn;
        logic [15:0] data;
        logic [15:0] exp;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    riders_pkg::cpu_bus_t cpu;
    logic                 cpu_req;
    logic                 snd_rd;
    logic                 snd_reply_we;
    logic [7:0]           snd_reply;
    logic [1:0]           debug_sel;
    logic                 cpu_ack;
    logic [15:0]          cpu_dout;
    logic                 prot_irqn;
    logic                 snd_irq;
    logic [7:0]           snd_cmd;
    logic [7:0]           debug_view;

    logic [15:0] oram_model [0:1023];
    step_t       steps [0:MAX_STEPS-1];
    int          n_steps;
    int          seed;
    int          checks;
    int          errors;
    int          timeouts;
    int          last_latency;
    logic [7:0]  last_addr_exp;
    logic [7:0]  snd_cmd_exp;

    riders_game riders_game_i (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cpu          ( cpu          ),
        .cpu_req      ( cpu_req      ),
        .snd_rd       ( snd_rd       ),
        .snd_reply_we ( snd_reply_we ),
        .snd_reply    ( snd_reply    ),
        .debug_sel    ( debug_sel    ),
        .cpu_ack      ( cpu_ack      ),
        .cpu_dout     ( cpu_dout     ),
        .prot_irqn    ( prot_irqn    ),
        .snd_irq      ( snd_irq      ),
        .snd_cmd      ( snd_cmd      ),
        .debug_view   ( debug_view   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Four-phase cycle with req up, ack wait, req down and ack low wait
    task automatic bus_cycle(input logic we, input logic [11:0] addr, input logic [1:0] dsn,
                             input logic [15:0] din, output logic [15:0] rdata);
        riders_pkg::cpu_bus_t word;
        int n;
        word.addr = addr;
        word.we   = we;
        word.dsn  = dsn;
        word.din  = din;
        @(posedge clk);
        cpu     <= word;
        cpu_req <= 1'b1;
        n = 0;
        @(posedge clk);
        while (!cpu_ack && n < ACK_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!cpu_ack) begin
            timeouts++;
            $display("Timeout: cpu_ack did not rise for the cycle at address %h", addr);
        end
        last_latency = n;
        rdata = cpu_dout;
        cpu_req <= 1'b0;
        n = 0;
        @(posedge clk);
        while (cpu_ack && n < ACK_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (cpu_ack) begin
            timeouts++;
            $display("Timeout: cpu_ack stayed high after the cycle at address %h", addr);
        end
        last_addr_exp = addr[7:0];
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [15:0] data);
        logic [15:0] unused;
        bus_cycle(1'b1, addr, 2'b00, data, unused);
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [15:0] exp);
        logic [15:0] rdata;
        bus_cycle(1'b0, addr, 2'b00, 16'h0000, rdata);
        check_word($sformatf("cpu_dout @%h", addr), rdata, exp);
    endtask

    // Byte lanes follow the active-low strobes
    task automatic model_write(input logic [11:0] addr, input logic [1:0] dsn,
                               input logic [15:0] data);
        if (addr[11:10] == 2'b00) begin
            if (!dsn[0])
                oram_model[addr[9:0]][7:0] = data[7:0];
            if (!dsn[1])
                oram_model[addr[9:0]][15:8] = data[15:8];
        end
    endtask

    task automatic add_write(input logic [11:0] addr, input logic [1:0] dsn,
                             input logic [15:0] data);
        steps[n_steps] = '{1'b0, addr, dsn, data, 16'h0000};
        n_steps++;
        model_write(addr, dsn, data);
    endtask

    task automatic add_read(input logic [11:0] addr, input logic [15:0] exp);
        steps[n_steps] = '{1'b1, addr, 2'b00, 16'h0000, exp};
        n_steps++;
    endtask

    task automatic start_dma(input riders_pkg::prot_cmd_e cmd, input logic [11:0] src,
                             input logic [11:0] dst, input int len);
        bus_write(PROT + 12'(riders_pkg::reg_dma_src), {4'd0, src});
        bus_write(PROT + 12'(riders_pkg::reg_dma_dst), {4'd0, dst});
        bus_write(PROT + 12'(riders_pkg::reg_dma_len), 16'(len));
        bus_write(PROT + 12'(riders_pkg::reg_command), {14'd0, cmd});
    endtask

    task automatic wait_prot_irq();
        int n;
        n = 0;
        while (prot_irqn && n < IRQ_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (prot_irqn) begin
            timeouts++;
            $display("Timeout: prot_irqn never went low after the DMA command");
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] rdata;
        logic [31:0] prod;
        logic [11:0] addr;
        logic [7:0]  reply;
        logic [7:0]  view_exp [0:3];
        int          i;
        int          len;

        seed          = 32'h02cce286;
        cpu           = '0;
        cpu_req       = 1'b0;
        snd_rd        = 1'b0;
        snd_reply_we  = 1'b0;
        snd_reply     = 8'h00;
        debug_sel     = 2'd0;
        rst_n         = 1'b0;
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        n_steps       = 0;
        last_latency  = 0;
        last_addr_exp = 8'h00;
        snd_cmd_exp   = 8'h00;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_word("cpu_ack", 16'(cpu_ack), 16'h0000);
        check_word("snd_irq", 16'(snd_irq), 16'h0000);
        check_word("debug_view", 16'(debug_view), 16'h0000);
        check_word("prot_irqn", 16'(prot_irqn), 16'h0001);

        // Known contents for the DMA regions
        for (i = 0; i < 128; i++) begin
            rnd = $random(seed);
            bus_write(12'(i), rnd[15:0]);
            model_write(12'(i), 2'b00, rnd[15:0]);
        end

        // Full words in the upper half followed by single-byte writes
        for (i = 0; i < 8; i++) begin
            rnd = $random(seed);
            add_write({3'b001, rnd[24:16]}, 2'b00, rnd[15:0]);
        end
        for (i = 0; i < 8; i++)
            add_read(steps[i].addr, oram_model[steps[i].addr[9:0]]);
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            add_write({5'd0, rnd[22:16]}, i[0] ? 2'b01 : 2'b10, rnd[15:0]);
        end
        for (i = 16; i < 20; i++)
            add_read(steps[i].addr, oram_model[steps[i].addr[9:0]]);
        add_write(12'h400, 2'b00, 16'hdead);
        add_read(12'h000, oram_model[0]);
        add_read(12'h400, 16'h0000);
        add_read(12'h7ff, 16'h0000);
        add_read(12'h808, 16'h0000);
        add_read(12'hbff, 16'h0000);
        add_read(12'hc02, 16'h0000);
        add_read(12'hfff, 16'h0000);

        // Multiplier keeps the low half of the product
        rnd  = $random(seed);
        a    = rnd[15:0];
        b    = rnd[31:16];
        prod = a * b;
        add_write(PROT + 12'(riders_pkg::reg_op_a), 2'b00, a);
        add_write(PROT + 12'(riders_pkg::reg_op_b), 2'b00, b);
        add_write(PROT + 12'(riders_pkg::reg_command), 2'b00, {14'd0, riders_pkg::cmd_mul});
        add_read(PROT + 12'(riders_pkg::reg_result), prod[15:0]);
        add_read(PROT + 12'(riders_pkg::reg_op_a), a);
        add_read(PROT + 12'(riders_pkg::reg_op_b), b);

        for (i = 0; i < n_steps; i++) begin
            bus_cycle(!steps[i].is_rd, steps[i].addr, steps[i].dsn, steps[i].data, rdata);
            if (steps[i].is_rd)
                check_word($sformatf("cpu_dout @%h", steps[i].addr), rdata, steps[i].exp);
            check_word("cpu_ack latency", 16'(last_latency), 16'd3);
        end

        // DMA copy 000.. to 040..
        rnd = $random(seed);
        len = int'(rnd[4:0]) + 1;
        start_dma(riders_pkg::cmd_dma_copy, 12'h000, 12'h040, len);
        wait_prot_irq();
        read_expect(PROT + 12'(riders_pkg::reg_status), 16'h0002);
        check_word("prot_irqn", 16'(prot_irqn), 16'h0001);
        read_expect(PROT + 12'(riders_pkg::reg_status), 16'h0000);
        for (i = 0; i < len; i++)
            oram_model[12'h040 + i] = oram_model[i];
        for (i = 0; i < len; i++) begin
            read_expect(12'h040 + 12'(i), oram_model[12'h040 + i]);
            read_expect(12'(i), oram_model[i]);
        end

        // DMA fill at 060 with a CPU read stalled behind it
        rnd = $random(seed);
        a   = rnd[15:0];
        len = int'(rnd[19:16]) + 1;
        bus_write(PROT + 12'(riders_pkg::reg_op_a), a);
        start_dma(riders_pkg::cmd_dma_fill, 12'h000, 12'h060, len);
        for (i = 0; i < len; i++)
            oram_model[12'h060 + i] = a;
        read_expect(12'h060, a);
        if (last_latency <= 3) begin
            errors++;
            $display("CPU read issued during the DMA fill was not held off");
        end
        wait_prot_irq();
        read_expect(PROT + 12'(riders_pkg::reg_status), 16'h0002);
        check_word("prot_irqn", 16'(prot_irqn), 16'h0001);
        read_expect(PROT + 12'(riders_pkg::reg_status), 16'h0000);
        for (i = -1; i <= len; i++)
            read_expect(12'h060 + 12'(i), oram_model[12'h060 + i]);

        // Sound command and reply latches
        rnd = $random(seed);
        bus_write(SND, rnd[15:0]);
        snd_cmd_exp = rnd[7:0];
        check_word("snd_irq", 16'(snd_irq), 16'h0001);
        check_word("snd_cmd", 16'(snd_cmd), 16'(snd_cmd_exp));
        @(posedge clk);
        snd_rd <= 1'b1;
        @(posedge clk);
        snd_rd <= 1'b0;
        @(posedge clk);
        check_word("snd_irq", 16'(snd_irq), 16'h0000);
        reply = rnd[23:16];
        snd_reply    <= reply;
        snd_reply_we <= 1'b1;
        @(posedge clk);
        snd_reply_we <= 1'b0;
        read_expect(SND + 12'd1, {8'h00, reply});
        read_expect(SND, {8'h00, snd_cmd_exp});

        // Leave an irq pending so the status byte is not zero
        addr = 12'h100;
        start_dma(riders_pkg::cmd_dma_fill, 12'h000, addr, 2);
        oram_model[addr[9:0]]     = a;
        oram_model[addr[9:0] + 1] = a;
        wait_prot_irq();
        view_exp[0] = 8'h02;
        view_exp[1] = snd_cmd_exp;
        view_exp[2] = last_addr_exp;
        view_exp[3] = 8'h00;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            debug_sel <= 2'(i);
            @(posedge clk);
            @(posedge clk);
            check_word($sformatf("debug_view sel %0d", i), 16'(debug_view), 16'(view_exp[i]));
        end
        read_expect(PROT + 12'(riders_pkg::reg_status), 16'h0002);
        read_expect(addr, oram_model[addr[9:0]]);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/riders_pkg.sv
logic/riders_addr_decode.sv
logic/riders_prot.sv
logic/riders_oram.sv
logic/riders_snd_latch.sv
logic/riders_game.sv
test/riders_game_tb.sv
